/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // ------------------------------------------------------------------------
  // Geometry
  // ------------------------------------------------------------------------
  localparam int NUM_SETS       = 8;
  localparam int WORDS_PER_LINE = 4;

  // Address field positions
  localparam int OFFSET_LSB = 2;
  localparam int INDEX_LSB  = 4;
  localparam int TAG_LSB    = 7;

  localparam logic [31:0] RESET_ADDR = 32'h0000_0000;

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [24:0]  tag_t;
  typedef logic [2:0]   index_t;
  typedef logic [1:0]   offset_t;
  typedef logic [127:0] line_t;
  typedef logic [3:0]   word_mask_t;

  // One wider than the offset so it can hold WORDS_PER_LINE
  typedef logic [2:0]   cnt_t;

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_spill_req,
    st_spill_wait,
    st_refill_req,
    st_refill_wait,
    st_fill_line,
    st_access,
    st_resp,
    st_resp_release
  } ctrl_state_t;

endpackage

`default_nettype wire

/* cache_arrays.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_arrays
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  index_t     index,
  input  tag_t       tag,
  input  logic       tag_wen,
  input  logic       data_wen,
  input  word_mask_t word_mask,
  input  line_t      line_wdata,
  input  logic       dirty_set,
  input  logic       dirty_clear,

  output tag_t       stored_tag,
  output logic       stored_valid,
  output logic       stored_dirty,
  output line_t      stored_line
);

  localparam int WORD_W = $bits(word_t);

  tag_t               tag_mem  [NUM_SETS];
  line_t              data_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits;
  logic [NUM_SETS-1:0] dirty_bits;

  // ------------------------------------------------------------------------
  // Tag stage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_mem[index] <= tag;
    end
  end

  // Valid comes up with the first tag write to a set
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (tag_wen) begin
      valid_bits[index] <= 1'b1;
    end
  end

  // Clear wins, a fill always starts clean
  always_ff @(posedge clk) begin
    if (reset) begin
      dirty_bits <= '0;
    end else if (dirty_clear) begin
      dirty_bits[index] <= 1'b0;
    end else if (dirty_set) begin
      dirty_bits[index] <= 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Data stage
  // ------------------------------------------------------------------------

  // Per-word write enables, full mask for a fill
  always_ff @(posedge clk) begin
    if (data_wen) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        if (word_mask[w]) begin
          data_mem[index][w*WORD_W +: WORD_W] <= line_wdata[w*WORD_W +: WORD_W];
        end
      end
    end
  end

  // Combinational read of the addressed set
  assign stored_tag   = tag_mem[index];
  assign stored_valid = valid_bits[index];
  assign stored_dirty = dirty_bits[index];
  assign stored_line  = data_mem[index];

endmodule

`default_nettype wire

/* cache_dpath.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_dpath
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  input  addr_t      proc_addr,
  input  word_t      proc_wdata,
  output word_t      proc_rdata,

  output addr_t      mem_addr,
  output word_t      mem_wdata,
  input  word_t      mem_rdata,

  // From the controller
  input  logic       req_en,
  input  logic       tag_wen,
  input  logic       dirty_set,
  input  logic       dirty_clear,
  input  logic       data_wen,
  input  logic       fill_sel,
  input  logic       spill_sel,
  input  logic       spill_step,
  input  logic       refill_step,
  input  logic       refill_capture,
  input  logic       cnt_clear,

  output logic       hit,
  output logic       dirty,
  output logic       spill_last,
  output logic       refill_last,

  // To and from the arrays
  input  tag_t       stored_tag,
  input  logic       stored_valid,
  input  logic       stored_dirty,
  input  line_t      stored_line,
  output index_t     index,
  output tag_t       tag,
  output line_t      line_wdata,
  output word_mask_t word_mask,
  output logic       arr_data_wen,
  output logic       arr_tag_wen,
  output logic       arr_dirty_set,
  output logic       arr_dirty_clear
);

  localparam int WORD_W = $bits(word_t);

  addr_t   req_addr;
  word_t   req_wdata;
  offset_t req_offset;
  cnt_t    spill_cnt;
  cnt_t    refill_cnt;
  line_t   refill_line;
  addr_t   spill_addr;
  addr_t   refill_addr;

  // ------------------------------------------------------------------------
  // Request registers and tag check
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      req_addr <= RESET_ADDR;
    end else if (req_en) begin
      req_addr <= proc_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_wdata <= proc_wdata;
    end
  end

  assign tag        = req_addr[31:TAG_LSB];
  assign index      = req_addr[TAG_LSB-1:INDEX_LSB];
  assign req_offset = req_addr[INDEX_LSB-1:OFFSET_LSB];

  assign hit   = stored_valid && (stored_tag == tag);
  assign dirty = stored_valid && stored_dirty;

  // ------------------------------------------------------------------------
  // Spill and refill sequencing
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || cnt_clear) begin
      spill_cnt  <= '0;
      refill_cnt <= '0;
    end else begin
      if (spill_step) begin
        spill_cnt <= spill_cnt + cnt_t'(1);
      end
      if (refill_step) begin
        refill_cnt <= refill_cnt + cnt_t'(1);
      end
    end
  end

  assign spill_last  = (spill_cnt == cnt_t'(WORDS_PER_LINE));
  assign refill_last = (refill_cnt == cnt_t'(WORDS_PER_LINE));

  // Victim address uses the stored tag and the fill address the request tag
  assign spill_addr  = {stored_tag, index, offset_t'(spill_cnt), {OFFSET_LSB{1'b0}}};
  assign refill_addr = {tag, index, offset_t'(refill_cnt), {OFFSET_LSB{1'b0}}};
  assign mem_addr    = spill_sel ? spill_addr : refill_addr;

  assign mem_wdata = stored_line[offset_t'(spill_cnt)*WORD_W +: WORD_W];

  // Refill words land at the current refill count
  always_ff @(posedge clk) begin
    if (refill_capture) begin
      refill_line[offset_t'(refill_cnt)*WORD_W +: WORD_W] <= mem_rdata;
    end
  end

  // ------------------------------------------------------------------------
  // Array write side and response
  // ------------------------------------------------------------------------

  assign line_wdata = fill_sel ? refill_line : {WORDS_PER_LINE{req_wdata}};
  assign word_mask  = fill_sel ? '1 : word_mask_t'(1) << req_offset;

  // Write strobes pass straight to the arrays
  assign arr_tag_wen     = tag_wen;
  assign arr_dirty_clear = dirty_clear;
  assign arr_data_wen    = data_wen;
  assign arr_dirty_set   = dirty_set;

  assign proc_rdata = stored_line[req_offset*WORD_W +: WORD_W];

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  logic clk,
  input  logic reset,

  input  logic proc_req,
  input  logic proc_write,
  output logic proc_ack,

  output logic mem_req,
  output logic mem_write,
  input  logic mem_ack,

  // Strobes to the datapath
  output logic req_en,
  output logic tag_wen,
  output logic dirty_set,
  output logic dirty_clear,
  output logic data_wen,
  output logic fill_sel,
  output logic spill_sel,
  output logic spill_step,
  output logic refill_step,
  output logic refill_capture,
  output logic cnt_clear,

  // Status from the datapath
  input  logic hit,
  input  logic dirty,
  input  logic spill_last,
  input  logic refill_last
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        req_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Store or load, taken with the address
  always_ff @(posedge clk) begin
    if (reset) begin
      req_write <= 1'b0;
    end else if (req_en) begin
      req_write <= proc_write;
    end
  end

  // ------------------------------------------------------------------------
  // Next state and outputs
  // ------------------------------------------------------------------------

  always_comb begin
    state_next     = state;
    proc_ack       = 1'b0;
    mem_req        = 1'b0;
    mem_write      = 1'b0;
    req_en         = 1'b0;
    tag_wen        = 1'b0;
    dirty_set      = 1'b0;
    dirty_clear    = 1'b0;
    data_wen       = 1'b0;
    fill_sel       = 1'b0;
    spill_sel      = 1'b0;
    spill_step     = 1'b0;
    refill_step    = 1'b0;
    refill_capture = 1'b0;
    cnt_clear      = 1'b0;

    unique case (state)
      st_idle: begin
        if (proc_req) begin
          req_en     = 1'b1;
          state_next = st_tag_check;
        end
      end

      st_tag_check: begin
        cnt_clear = 1'b1;
        if (hit) begin
          state_next = st_access;
        end else if (dirty) begin
          state_next = st_spill_req;
        end else begin
          state_next = st_refill_req;
        end
      end

      // Write back the victim, one handshake per word
      st_spill_req: begin
        mem_req   = 1'b1;
        mem_write = 1'b1;
        spill_sel = 1'b1;
        if (mem_ack) begin
          spill_step = 1'b1;
          state_next = st_spill_wait;
        end
      end

      st_spill_wait: begin
        mem_write = 1'b1;
        spill_sel = 1'b1;
        if (!mem_ack) begin
          state_next = spill_last ? st_refill_req : st_spill_req;
        end
      end

      // Read data is only valid while mem_ack is high
      st_refill_req: begin
        mem_req = 1'b1;
        if (mem_ack) begin
          refill_capture = 1'b1;
          refill_step    = 1'b1;
          state_next     = st_refill_wait;
        end
      end

      st_refill_wait: begin
        if (!mem_ack) begin
          state_next = refill_last ? st_fill_line : st_refill_req;
        end
      end

      st_fill_line: begin
        fill_sel    = 1'b1;
        tag_wen     = 1'b1;
        data_wen    = 1'b1;
        dirty_clear = 1'b1;
        state_next  = st_access;
      end

      st_access: begin
        if (req_write) begin
          data_wen  = 1'b1;
          dirty_set = 1'b1;
        end
        state_next = st_resp;
      end

      st_resp: begin
        proc_ack   = 1'b1;
        state_next = st_resp_release;
      end

      // Hold ack until the processor lets go
      st_resp_release: begin
        proc_ack = 1'b1;
        if (!proc_req) begin
          state_next = st_idle;
        end
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_top
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  input  logic  proc_req,
  input  logic  proc_write,
  input  addr_t proc_addr,
  input  word_t proc_wdata,
  output logic  proc_ack,
  output word_t proc_rdata,

  output logic  mem_req,
  output logic  mem_write,
  output addr_t mem_addr,
  output word_t mem_wdata,
  input  logic  mem_ack,
  input  word_t mem_rdata
);

  // Controller strobes
  logic req_en;
  logic tag_wen;
  logic dirty_set;
  logic dirty_clear;
  logic data_wen;
  logic fill_sel;
  logic spill_sel;
  logic spill_step;
  logic refill_step;
  logic refill_capture;
  logic cnt_clear;

  // Datapath status
  logic hit;
  logic dirty;
  logic spill_last;
  logic refill_last;

  // Array side
  index_t     index;
  tag_t       tag;
  line_t      line_wdata;
  word_mask_t word_mask;
  logic       arr_data_wen;
  logic       arr_tag_wen;
  logic       arr_dirty_set;
  logic       arr_dirty_clear;
  tag_t       stored_tag;
  logic       stored_valid;
  logic       stored_dirty;
  line_t      stored_line;

  cache_ctrl ctrl (
    .clk            (clk),
    .reset          (reset),
    .proc_req       (proc_req),
    .proc_write     (proc_write),
    .proc_ack       (proc_ack),
    .mem_req        (mem_req),
    .mem_write      (mem_write),
    .mem_ack        (mem_ack),
    .req_en         (req_en),
    .tag_wen        (tag_wen),
    .dirty_set      (dirty_set),
    .dirty_clear    (dirty_clear),
    .data_wen       (data_wen),
    .fill_sel       (fill_sel),
    .spill_sel      (spill_sel),
    .spill_step     (spill_step),
    .refill_step    (refill_step),
    .refill_capture (refill_capture),
    .cnt_clear      (cnt_clear),
    .hit            (hit),
    .dirty          (dirty),
    .spill_last     (spill_last),
    .refill_last    (refill_last)
  );

  cache_dpath dpath (
    .clk             (clk),
    .reset           (reset),
    .proc_addr       (proc_addr),
    .proc_wdata      (proc_wdata),
    .proc_rdata      (proc_rdata),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_rdata       (mem_rdata),
    .req_en          (req_en),
    .tag_wen         (tag_wen),
    .dirty_set       (dirty_set),
    .dirty_clear     (dirty_clear),
    .data_wen        (data_wen),
    .fill_sel        (fill_sel),
    .spill_sel       (spill_sel),
    .spill_step      (spill_step),
    .refill_step     (refill_step),
    .refill_capture  (refill_capture),
    .cnt_clear       (cnt_clear),
    .hit             (hit),
    .dirty           (dirty),
    .spill_last      (spill_last),
    .refill_last     (refill_last),
    .stored_tag      (stored_tag),
    .stored_valid    (stored_valid),
    .stored_dirty    (stored_dirty),
    .stored_line     (stored_line),
    .index           (index),
    .tag             (tag),
    .line_wdata      (line_wdata),
    .word_mask       (word_mask),
    .arr_data_wen    (arr_data_wen),
    .arr_tag_wen     (arr_tag_wen),
    .arr_dirty_set   (arr_dirty_set),
    .arr_dirty_clear (arr_dirty_clear)
  );

  cache_arrays arrays (
    .clk          (clk),
    .reset        (reset),
    .index        (index),
    .tag          (tag),
    .tag_wen      (arr_tag_wen),
    .data_wen     (arr_data_wen),
    .word_mask    (word_mask),
    .line_wdata   (line_wdata),
    .dirty_set    (arr_dirty_set),
    .dirty_clear  (arr_dirty_clear),
    .stored_tag   (stored_tag),
    .stored_valid (stored_valid),
    .stored_dirty (stored_dirty),
    .stored_line  (stored_line)
  );

endmodule

`default_nettype wire

/* cache_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_properties (
  input logic clk,
  input logic reset,
  input logic proc_req,
  input logic proc_ack,
  input logic mem_req,
  input logic mem_ack
);

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(proc_ack) |-> proc_req)
    else $error("proc_ack rose while proc_req was low");

  // Request held until the memory has answered
  mem_req_held: assert property (@(posedge clk) disable iff (reset)
    $fell(mem_req) |-> mem_ack)
    else $error("mem_req dropped before mem_ack");

  reset_quiet: assert property (@(posedge clk)
    reset |=> (!proc_ack && !mem_req))
    else $error("proc_ack or mem_req high after reset");

endmodule

bind cache_ctrl cache_properties props (
  .clk      (clk),
  .reset    (reset),
  .proc_req (proc_req),
  .proc_ack (proc_ack),
  .mem_req  (mem_req),
  .mem_ack  (mem_ack)
);

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache
  import cache_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int NUM_OPS    = 21;
  localparam int HS_LIMIT   = 100;
  localparam int MEM_WORDS  = 256;

  typedef struct packed {
    logic  is_write;
    addr_t addr;
    logic  exp_hit;
    logic  exp_spill;
  } op_t;

  logic  clk;
  logic  reset;
  logic  proc_req;
  logic  proc_write;
  addr_t proc_addr;
  word_t proc_wdata;
  logic  proc_ack;
  word_t proc_rdata;
  logic  mem_req;
  logic  mem_write;
  addr_t mem_addr;
  word_t mem_wdata;
  logic  mem_ack   = 1'b0;
  word_t mem_rdata = '0;

  // Shadow holds the memory contents and ref_mem what a load must return
  word_t       shadow_mem [MEM_WORDS];
  word_t       ref_mem    [MEM_WORDS];
  addr_t       res_base   [NUM_SETS];
  op_t         ops        [NUM_OPS];
  addr_t       exp_addr_q [$];
  logic        exp_write_q [$];
  logic [15:0] lfsr_state;

  cache_top UUT (
    .clk        (clk),
    .reset      (reset),
    .proc_req   (proc_req),
    .proc_write (proc_write),
    .proc_addr  (proc_addr),
    .proc_wdata (proc_wdata),
    .proc_ack   (proc_ack),
    .proc_rdata (proc_rdata),
    .mem_req    (mem_req),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Failure reporting and compares
  // ------------------------------------------------------------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------------------
  // Random store data
  // ------------------------------------------------------------------------

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_word(output word_t w);
    for (int b = 0; b < $bits(word_t); b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  // ------------------------------------------------------------------------
  // Memory responder
  // ------------------------------------------------------------------------

  always @(posedge clk) begin : mem_responder
    addr_t want_addr;
    logic  want_write;
    if (reset) begin
      mem_ack <= 1'b0;
    end else if (mem_req && !mem_ack) begin
      if (exp_addr_q.size() == 0) begin
        fail_run("Memory handshake started when none was expected");
      end
      want_addr  = exp_addr_q.pop_front();
      want_write = exp_write_q.pop_front();
      check_addr("mem_addr", mem_addr, want_addr);
      check_flag("mem_write", mem_write, want_write);
      if (mem_write) begin
        // Spilled words must hold the latest stored values
        check_word("mem_wdata", mem_wdata, ref_mem[mem_addr[9:2]]);
        shadow_mem[mem_addr[9:2]] = mem_wdata;
      end else begin
        mem_rdata <= shadow_mem[mem_addr[9:2]];
      end
      mem_ack <= 1'b1;
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Processor side
  // ------------------------------------------------------------------------

  task automatic run_access(input logic is_write, input addr_t addr,
                            input word_t wdata, output word_t rdata);
    int waited;
    proc_req   <= 1'b1;
    proc_write <= is_write;
    proc_addr  <= addr;
    proc_wdata <= wdata;
    waited = 0;
    @(posedge clk);
    while (proc_ack !== 1'b1) begin
      if (waited == HS_LIMIT) begin
        fail_run($sformatf("Request to address %h was never acknowledged", addr));
      end
      waited++;
      @(posedge clk);
    end
    rdata = proc_rdata;
    proc_req <= 1'b0;
    waited = 0;
    @(posedge clk);
    while (proc_ack !== 1'b0) begin
      if (waited == HS_LIMIT) begin
        fail_run("Cache kept proc_ack high after the request was released");
      end
      waited++;
      @(posedge clk);
    end
  endtask

  // Write, address, expect hit, expect dirty victim
  task automatic load_table();
    ops[0]  = '{1'b0, 32'h0000_0040, 1'b0, 1'b0};
    ops[1]  = '{1'b0, 32'h0000_0048, 1'b1, 1'b0};
    ops[2]  = '{1'b1, 32'h0000_0044, 1'b1, 1'b0};
    ops[3]  = '{1'b0, 32'h0000_0044, 1'b1, 1'b0};
    ops[4]  = '{1'b0, 32'h0000_004C, 1'b1, 1'b0};
    ops[5]  = '{1'b0, 32'h0000_0040, 1'b1, 1'b0};
    ops[6]  = '{1'b1, 32'h0000_01A8, 1'b0, 1'b0};
    ops[7]  = '{1'b0, 32'h0000_01A8, 1'b1, 1'b0};
    ops[8]  = '{1'b0, 32'h0000_01A0, 1'b1, 1'b0};
    ops[9]  = '{1'b0, 32'h0000_00C0, 1'b0, 1'b1};
    ops[10] = '{1'b0, 32'h0000_0044, 1'b0, 1'b0};
    ops[11] = '{1'b1, 32'h0000_0228, 1'b0, 1'b1};
    ops[12] = '{1'b0, 32'h0000_01A8, 1'b0, 1'b1};
    ops[13] = '{1'b0, 32'h0000_0228, 1'b0, 1'b0};
    ops[14] = '{1'b1, 32'h0000_03FC, 1'b0, 1'b0};
    ops[15] = '{1'b1, 32'h0000_03F0, 1'b1, 1'b0};
    ops[16] = '{1'b0, 32'h0000_03FC, 1'b1, 1'b0};
    ops[17] = '{1'b0, 32'h0000_037C, 1'b0, 1'b1};
    ops[18] = '{1'b0, 32'h0000_03F0, 1'b0, 1'b0};
    ops[19] = '{1'b1, 32'h0000_0010, 1'b0, 1'b0};
    ops[20] = '{1'b0, 32'h0000_0010, 1'b1, 1'b0};
  endtask

  initial begin
    #(NUM_OPS * 200 * CLK_PERIOD);
    fail_run("Watchdog expired before the operation table finished");
  end

  initial begin
    word_t  rdata;
    word_t  wdata;
    addr_t  line_base;
    index_t set;
    reset      = 1'b1;
    proc_req   = 1'b0;
    proc_write = 1'b0;
    proc_addr  = '0;
    proc_wdata = '0;
    lfsr_state = 16'd17950;
    for (int a = 0; a < MEM_WORDS; a++) begin
      shadow_mem[a] = word_t'(a * 4) ^ 32'hA5A5_A5A5;
      ref_mem[a]    = shadow_mem[a];
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      res_base[s] = '0;
    end
    load_table();

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // Idle after reset before any request
    repeat (3) begin
      @(posedge clk);
      check_flag("proc_ack", proc_ack, 1'b0);
      check_flag("mem_req", mem_req, 1'b0);
    end

    for (int i = 0; i < NUM_OPS; i++) begin
      set       = ops[i].addr[TAG_LSB-1:INDEX_LSB];
      line_base = {ops[i].addr[31:INDEX_LSB], {INDEX_LSB{1'b0}}};
      if (!ops[i].exp_hit) begin
        if (ops[i].exp_spill) begin
          for (int k = 0; k < WORDS_PER_LINE; k++) begin
            exp_addr_q.push_back(res_base[set] + addr_t'(k * 4));
            exp_write_q.push_back(1'b1);
          end
        end
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
          exp_addr_q.push_back(line_base + addr_t'(k * 4));
          exp_write_q.push_back(1'b0);
        end
        res_base[set] = line_base;
      end
      wdata = '0;
      if (ops[i].is_write) begin
        draw_word(wdata);
      end
      run_access(ops[i].is_write, ops[i].addr, wdata, rdata);
      if (exp_addr_q.size() != 0) begin
        fail_run($sformatf("Operation %0d ended with memory handshakes missing", i));
      end
      if (ops[i].is_write) begin
        ref_mem[ops[i].addr[9:2]] = wdata;
      end else begin
        check_word("proc_rdata", rdata, ref_mem[ops[i].addr[9:2]]);
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
cache_pkg.sv
cache_arrays.sv
cache_dpath.sv
cache_ctrl.sv
cache_top.sv
cache_properties.sv
tb_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache -f sim.f -o tb_cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_cache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished cleanly"
exit 0
